// ==== src/accel_pkg.sv ====
package accel_pkg;

    // ==============================
    // Lane and address widths
    // ==============================

    // One signed lane of a port word
    localparam int LANE_W = 8;

    // Off-chip word address
    localparam int MEM_ADDR_W = 32;

    // Word count field of a transfer request
    localparam int XFER_CNT_W = 16;

    // ==============================
    // Port command word
    // ==============================

    // Encoded in bit 0 of the command word
    typedef enum logic {
        DIR_LOAD  = 1'b0,
        DIR_STORE = 1'b1
    } dir_e;

    // Sits in the low 33 bits of the port word, upper bits zero
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        dir_e                  dir;
    } cmd_t;

    // One transfer request from the sequencer to the port engine
    typedef struct packed {
        dir_e                  dir;
        logic [MEM_ADDR_W-1:0] addr;
        logic [XFER_CNT_W-1:0] cnt;
    } xfer_req_t;

endpackage

// ==== src/word_buf.sv ====
`timescale 1ns/1ps

module word_buf #(
    parameter int PORT_WIDTH = 128,
    parameter int BUF_DEPTH  = 16
) (
    input  logic                         clk,
    input  logic                         wr_en,
    input  logic [$clog2(BUF_DEPTH)-1:0] wr_idx,
    input  logic [PORT_WIDTH-1:0]        wr_dat,
    input  logic                         rd_en,
    input  logic [$clog2(BUF_DEPTH)-1:0] rd_idx,
    output logic [PORT_WIDTH-1:0]        rd_dat
);

    // Block storage, one word per entry
    logic [PORT_WIDTH-1:0] mem [BUF_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_dat;
        end
    end

    // Registered read, data one cycle after rd_en
    // Holds the last word while no read is issued
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_dat <= mem[rd_idx];
        end
    end

endmodule

// ==== src/relu_unit.sv ====
`timescale 1ns/1ps

module relu_unit #(
    parameter int PORT_WIDTH = 128,
    parameter int IDX_W      = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_vld,
    input  logic [IDX_W-1:0]      in_idx,
    input  logic [PORT_WIDTH-1:0] in_dat,
    output logic                  out_vld,
    output logic [IDX_W-1:0]      out_idx,
    output logic [PORT_WIDTH-1:0] out_dat
);
    import accel_pkg::*;

    localparam int LANES = PORT_WIDTH / LANE_W;

    // Stage 1 registers
    logic                  s1_vld;
    logic [IDX_W-1:0]      s1_idx;
    logic [PORT_WIDTH-1:0] s1_dat;
    logic [LANES-1:0]      s1_neg;

    // ==============================
    // Valid pipe
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld  <= 1'b0;
            out_vld <= 1'b0;
        end else begin
            s1_vld  <= in_vld;
            out_vld <= s1_vld;
        end
    end

    // Stage 1: capture word, flag lanes with sign bit set
    always_ff @(posedge clk) begin
        s1_idx <= in_idx;
        s1_dat <= in_dat;
        for (int i = 0; i < LANES; i++) begin
            s1_neg[i] <= in_dat[i*LANE_W + LANE_W - 1];
        end
    end

    // Stage 2: zero flagged lanes
    // Index rides along for the write-back
    always_ff @(posedge clk) begin
        out_idx <= s1_idx;
        for (int i = 0; i < LANES; i++) begin
            out_dat[i*LANE_W +: LANE_W] <= s1_neg[i] ? '0 : s1_dat[i*LANE_W +: LANE_W];
        end
    end

endmodule

// ==== src/port_ctrl.sv ====
`timescale 1ns/1ps

module port_ctrl #(
    parameter int PORT_WIDTH = 128,
    parameter int BUF_DEPTH  = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         xfer_req,
    input  accel_pkg::xfer_req_t         xfer_cfg,
    input  logic [PORT_WIDTH-1:0]        mem_dat,
    input  logic                         mem_vld,
    input  logic                         mem_rdy,
    input  logic [PORT_WIDTH-1:0]        buf_rdata,
    output logic                         xfer_done,
    output logic                         dat_oe,
    output logic                         cmd_vld,
    output logic [PORT_WIDTH-1:0]        chip_dat,
    output logic                         chip_vld,
    output logic                         chip_rdy,
    output logic                         ld_wr_en,
    output logic [$clog2(BUF_DEPTH)-1:0] ld_wr_idx,
    output logic [PORT_WIDTH-1:0]        ld_wr_dat,
    output logic                         st_rd_en,
    output logic [$clog2(BUF_DEPTH)-1:0] st_rd_idx
);
    import accel_pkg::*;

    localparam int IDX_W = $clog2(BUF_DEPTH);

    typedef enum logic [2:0] {
        S_IDLE,
        S_OPEN,
        S_CMD,
        S_LOAD,
        S_STORE,
        S_CLOSE
    } state_e;

    state_e                state;
    xfer_req_t             cfg;
    cmd_t                  cmd;

    // Word counters
    logic [XFER_CNT_W-1:0] moved;
    logic [XFER_CNT_W-1:0] rd_ptr;
    logic                  beat;
    logic                  last;

    // Store prefetch: output word, skid word, read in flight
    logic                  o_vld;
    logic [PORT_WIDTH-1:0] o_dat;
    logic                  s_vld;
    logic [PORT_WIDTH-1:0] s_dat;
    logic                  rd_pend;
    logic [1:0]            occ;
    logic                  pop;
    logic                  st_act;

    // ==============================
    // Transaction FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (xfer_req) begin
                        state <= S_OPEN;
                    end
                end
                // Opening pulse, memory leaves idle
                S_OPEN: state <= S_CMD;
                // Command word held until accepted
                S_CMD: begin
                    if (mem_rdy) begin
                        if (cfg.dir == DIR_STORE) begin
                            state <= S_STORE;
                        end else begin
                            state <= S_LOAD;
                        end
                    end
                end
                S_LOAD, S_STORE: begin
                    if (last) begin
                        state <= S_CLOSE;
                    end
                end
                // Closing pulse, memory back to idle
                S_CLOSE: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // ==============================
    // Counting and prefetch control
    // ==============================
    assign pop  = (state == S_STORE) && o_vld && mem_rdy;
    assign beat = ((state == S_LOAD) && mem_vld) || pop;
    assign last = beat && ((moved + 1'b1) == cfg.cnt);

    // Words held or on their way, at most two
    assign occ    = {1'b0, o_vld} + {1'b0, s_vld} + {1'b0, rd_pend};
    assign st_act = ((state == S_CMD) && (cfg.dir == DIR_STORE)) || (state == S_STORE);

    // Prefetch starts while the command word waits
    assign st_rd_en  = st_act && (rd_ptr != cfg.cnt) && ((occ - {1'b0, pop}) < 2'd2);
    assign st_rd_idx = rd_ptr[IDX_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            moved   <= '0;
            rd_ptr  <= '0;
            rd_pend <= 1'b0;
            o_vld   <= 1'b0;
            s_vld   <= 1'b0;
        end else begin
            if (state == S_OPEN) begin
                moved  <= '0;
                rd_ptr <= '0;
            end else begin
                if (beat) begin
                    moved <= moved + 1'b1;
                end
                if (st_rd_en) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            rd_pend <= st_rd_en;
            // Skid drains first, keeps word order
            if (pop || !o_vld) begin
                o_vld <= s_vld | rd_pend;
                s_vld <= 1'b0;
            end else if (rd_pend) begin
                s_vld <= 1'b1;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && xfer_req) begin
            cfg <= xfer_cfg;
        end
        if (pop || !o_vld) begin
            o_dat <= s_vld ? s_dat : buf_rdata;
        end else if (rd_pend) begin
            s_dat <= buf_rdata;
        end
    end

    // ==============================
    // Port outputs
    // ==============================
    assign cmd = '{addr: cfg.addr, dir: cfg.dir};

    always_comb begin
        dat_oe   = 1'b0;
        chip_vld = 1'b0;
        chip_dat = o_dat;
        case (state)
            S_CMD: begin
                dat_oe   = 1'b1;
                chip_vld = 1'b1;
                chip_dat = PORT_WIDTH'(cmd);
            end
            S_STORE: begin
                dat_oe   = 1'b1;
                chip_vld = o_vld;
            end
            // Store keeps ownership through the close
            S_CLOSE: dat_oe = (cfg.dir == DIR_STORE);
            default: dat_oe = 1'b0;
        endcase
    end

    assign cmd_vld   = (state == S_OPEN) || (state == S_CLOSE);
    assign xfer_done = (state == S_CLOSE);
    assign chip_rdy  = (state == S_LOAD);

    // Load words go straight into the buffer
    assign ld_wr_en  = (state == S_LOAD) && mem_vld;
    assign ld_wr_idx = moved[IDX_W-1:0];
    assign ld_wr_dat = mem_dat;

endmodule

// ==== src/net_seq.sv ====
`timescale 1ns/1ps

module net_seq #(
    parameter int PORT_WIDTH = 128,
    parameter int BUF_DEPTH  = 16
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic [accel_pkg::MEM_ADDR_W-1:0] src_addr,
    input  logic [accel_pkg::MEM_ADDR_W-1:0] dst_addr,
    input  logic [$clog2(BUF_DEPTH+1)-1:0]  word_cnt,
    input  logic                            xfer_done,
    input  logic [PORT_WIDTH-1:0]           buf_rdata,
    input  logic                            relu_vld,
    input  logic [$clog2(BUF_DEPTH)-1:0]    relu_idx,
    input  logic [PORT_WIDTH-1:0]           relu_dat,
    output logic                            xfer_req,
    output accel_pkg::xfer_req_t            xfer_cfg,
    output logic                            cmp_rd_en,
    output logic [$clog2(BUF_DEPTH)-1:0]    cmp_rd_idx,
    output logic                            cmp_vld,
    output logic [$clog2(BUF_DEPTH)-1:0]    cmp_idx,
    output logic [PORT_WIDTH-1:0]           cmp_dat,
    output logic                            cmp_wr_en,
    output logic [$clog2(BUF_DEPTH)-1:0]    cmp_wr_idx,
    output logic [PORT_WIDTH-1:0]           cmp_wr_dat,
    output logic                            busy,
    output logic                            net_fnh
);
    import accel_pkg::*;

    localparam int IDX_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH+1);

    typedef enum logic [2:0] {
        N_IDLE,
        N_LOAD,
        N_COMP,
        N_STORE,
        N_FNH
    } state_e;

    state_e                state;
    logic [CNT_W-1:0]      cnt_q;
    logic [MEM_ADDR_W-1:0] dst_q;
    // Compute cycle, one spare bit for the drain
    logic [CNT_W:0]        step;
    logic                  go;
    logic                  comp_end;

    // Start only counts when idle or finished
    assign go       = start && ((state == N_IDLE) || (state == N_FNH));
    // Last read plus three cycles of pipeline
    assign comp_end = (state == N_COMP) && (step == ({1'b0, cnt_q} + 2'd2));

    // ==============================
    // Phase FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= N_IDLE;
            xfer_req <= 1'b0;
            busy     <= 1'b0;
            net_fnh  <= 1'b0;
            step     <= '0;
            cmp_vld  <= 1'b0;
        end else begin
            xfer_req <= 1'b0;
            // Buffer data lands one cycle after the read
            cmp_vld  <= cmp_rd_en;
            case (state)
                N_IDLE, N_FNH: begin
                    if (go) begin
                        state    <= N_LOAD;
                        xfer_req <= 1'b1;
                        busy     <= 1'b1;
                        net_fnh  <= 1'b0;
                    end
                end
                N_LOAD: begin
                    if (xfer_done) begin
                        state <= N_COMP;
                        step  <= '0;
                    end
                end
                N_COMP: begin
                    step <= step + 1'b1;
                    if (comp_end) begin
                        state    <= N_STORE;
                        xfer_req <= 1'b1;
                    end
                end
                N_STORE: begin
                    if (xfer_done) begin
                        state   <= N_FNH;
                        busy    <= 1'b0;
                        net_fnh <= 1'b1;
                    end
                end
                default: state <= N_IDLE;
            endcase
        end
    end

    // Run settings and transfer requests
    always_ff @(posedge clk) begin
        cmp_idx <= cmp_rd_idx;
        if (go) begin
            cnt_q    <= word_cnt;
            dst_q    <= dst_addr;
            xfer_cfg <= '{dir: DIR_LOAD, addr: src_addr, cnt: XFER_CNT_W'(word_cnt)};
        end else if (comp_end) begin
            xfer_cfg <= '{dir: DIR_STORE, addr: dst_q, cnt: XFER_CNT_W'(cnt_q)};
        end
    end

    // ==============================
    // Compute datapath hookup
    // ==============================

    // One read per cycle for the first cnt_q steps
    assign cmp_rd_en  = (state == N_COMP) && (step < {1'b0, cnt_q});
    assign cmp_rd_idx = step[IDX_W-1:0];
    assign cmp_dat    = buf_rdata;

    // ReLU results back to the same entry
    assign cmp_wr_en  = relu_vld && (state == N_COMP);
    assign cmp_wr_idx = relu_idx;
    assign cmp_wr_dat = relu_dat;

endmodule

// ==== src/accel_top.sv ====
`timescale 1ns/1ps

module accel_top #(
    parameter int PORT_WIDTH = 128,
    parameter int BUF_DEPTH  = 16
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic [accel_pkg::MEM_ADDR_W-1:0] src_addr,
    input  logic [accel_pkg::MEM_ADDR_W-1:0] dst_addr,
    input  logic [$clog2(BUF_DEPTH+1)-1:0]  word_cnt,
    input  logic [PORT_WIDTH-1:0]           mem_dat,
    input  logic                            mem_vld,
    input  logic                            mem_rdy,
    output logic                            dat_oe,
    output logic                            cmd_vld,
    output logic [PORT_WIDTH-1:0]           chip_dat,
    output logic                            chip_vld,
    output logic                            chip_rdy,
    output logic                            net_fnh,
    output logic                            busy
);
    import accel_pkg::*;

    localparam int IDX_W = $clog2(BUF_DEPTH);

    // Sequencer to port engine
    logic                  xfer_req;
    xfer_req_t             xfer_cfg;
    logic                  xfer_done;

    // Port engine side of the buffer
    logic                  ld_wr_en;
    logic [IDX_W-1:0]      ld_wr_idx;
    logic [PORT_WIDTH-1:0] ld_wr_dat;
    logic                  st_rd_en;
    logic [IDX_W-1:0]      st_rd_idx;

    // Compute side of the buffer
    logic                  cmp_rd_en;
    logic [IDX_W-1:0]      cmp_rd_idx;
    logic                  cmp_vld;
    logic [IDX_W-1:0]      cmp_idx;
    logic [PORT_WIDTH-1:0] cmp_dat;
    logic                  cmp_wr_en;
    logic [IDX_W-1:0]      cmp_wr_idx;
    logic [PORT_WIDTH-1:0] cmp_wr_dat;
    logic                  relu_vld;
    logic [IDX_W-1:0]      relu_idx;
    logic [PORT_WIDTH-1:0] relu_dat;

    // Buffer ports after the owner select
    logic                  buf_wr_en;
    logic [IDX_W-1:0]      buf_wr_idx;
    logic [PORT_WIDTH-1:0] buf_wr_dat;
    logic                  buf_rd_en;
    logic [IDX_W-1:0]      buf_rd_idx;
    logic [PORT_WIDTH-1:0] buf_rdata;

    // ==============================
    // Buffer owner select
    // ==============================
    // Phases never overlap, the active enable picks the source
    assign buf_wr_en  = ld_wr_en | cmp_wr_en;
    assign buf_wr_idx = cmp_wr_en ? cmp_wr_idx : ld_wr_idx;
    assign buf_wr_dat = cmp_wr_en ? cmp_wr_dat : ld_wr_dat;
    assign buf_rd_en  = st_rd_en | cmp_rd_en;
    assign buf_rd_idx = cmp_rd_en ? cmp_rd_idx : st_rd_idx;

    net_seq #(
        .PORT_WIDTH (PORT_WIDTH),
        .BUF_DEPTH  (BUF_DEPTH)
    ) u_net_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .word_cnt   (word_cnt),
        .xfer_done  (xfer_done),
        .buf_rdata  (buf_rdata),
        .relu_vld   (relu_vld),
        .relu_idx   (relu_idx),
        .relu_dat   (relu_dat),
        .xfer_req   (xfer_req),
        .xfer_cfg   (xfer_cfg),
        .cmp_rd_en  (cmp_rd_en),
        .cmp_rd_idx (cmp_rd_idx),
        .cmp_vld    (cmp_vld),
        .cmp_idx    (cmp_idx),
        .cmp_dat    (cmp_dat),
        .cmp_wr_en  (cmp_wr_en),
        .cmp_wr_idx (cmp_wr_idx),
        .cmp_wr_dat (cmp_wr_dat),
        .busy       (busy),
        .net_fnh    (net_fnh)
    );

    port_ctrl #(
        .PORT_WIDTH (PORT_WIDTH),
        .BUF_DEPTH  (BUF_DEPTH)
    ) u_port_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .xfer_req   (xfer_req),
        .xfer_cfg   (xfer_cfg),
        .mem_dat    (mem_dat),
        .mem_vld    (mem_vld),
        .mem_rdy    (mem_rdy),
        .buf_rdata  (buf_rdata),
        .xfer_done  (xfer_done),
        .dat_oe     (dat_oe),
        .cmd_vld    (cmd_vld),
        .chip_dat   (chip_dat),
        .chip_vld   (chip_vld),
        .chip_rdy   (chip_rdy),
        .ld_wr_en   (ld_wr_en),
        .ld_wr_idx  (ld_wr_idx),
        .ld_wr_dat  (ld_wr_dat),
        .st_rd_en   (st_rd_en),
        .st_rd_idx  (st_rd_idx)
    );

    word_buf #(
        .PORT_WIDTH (PORT_WIDTH),
        .BUF_DEPTH  (BUF_DEPTH)
    ) u_word_buf (
        .clk        (clk),
        .wr_en      (buf_wr_en),
        .wr_idx     (buf_wr_idx),
        .wr_dat     (buf_wr_dat),
        .rd_en      (buf_rd_en),
        .rd_idx     (buf_rd_idx),
        .rd_dat     (buf_rdata)
    );

    relu_unit #(
        .PORT_WIDTH (PORT_WIDTH),
        .IDX_W      (IDX_W)
    ) u_relu_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_vld     (cmp_vld),
        .in_idx     (cmp_idx),
        .in_dat     (cmp_dat),
        .out_vld    (relu_vld),
        .out_idx    (relu_idx),
        .out_dat    (relu_dat)
    );

endmodule

// ==== verif/offchip_mem.sv ====
`timescale 1ns/1ps

module offchip_mem #(
    parameter int PORT_WIDTH = 128,
    parameter int DEPTH      = 4096
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dat_oe,
    input  logic                  cmd_vld,
    input  logic [PORT_WIDTH-1:0] chip_dat,
    input  logic                  chip_vld,
    input  logic                  chip_rdy,
    output logic [PORT_WIDTH-1:0] mem_dat,
    output logic                  mem_vld,
    output logic                  mem_rdy
);
    import accel_pkg::*;

    localparam int AW = $clog2(DEPTH);

    typedef enum logic [1:0] {
        M_IDLE,
        M_CMD,
        M_READ,
        M_WRITE
    } state_e;

    logic [PORT_WIDTH-1:0] mem [DEPTH];
    state_e                state;
    cmd_t                  cmd;
    logic [AW-1:0]         ptr;

    // One 128-bit word from 32-bit draws
    function automatic logic [PORT_WIDTH-1:0] random_word();
        logic [PORT_WIDTH-1:0] w;
        w = '0;
        for (int j = 0; j < PORT_WIDTH / 32; j++) begin
            w[j*32 +: 32] = $urandom;
        end
        return w;
    endfunction

    // Roughly one stall in four
    function automatic logic no_stall();
        return ($urandom % 4) != 0;
    endfunction

    // Command word sits in the low bits of the port word
    assign cmd = cmd_t'(chip_dat[$bits(cmd_t)-1:0]);

    // ==============================
    // Port state machine
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= M_IDLE;
            ptr     <= '0;
            mem_vld <= 1'b0;
            mem_rdy <= 1'b0;
            mem_dat <= '0;
            // Contents redrawn while reset is held
            for (int a = 0; a < DEPTH; a++) begin
                mem[a] <= random_word();
            end
        end else begin
            case (state)
                // Opening pulse
                M_IDLE: begin
                    if (cmd_vld) begin
                        state   <= M_CMD;
                        mem_rdy <= no_stall();
                    end
                end
                M_CMD: begin
                    mem_rdy <= no_stall();
                    if (dat_oe && chip_vld && mem_rdy) begin
                        ptr <= cmd.addr[AW-1:0];
                        if (cmd.dir == DIR_STORE) begin
                            state <= M_WRITE;
                        end else begin
                            state   <= M_READ;
                            mem_rdy <= 1'b0;
                            mem_vld <= no_stall();
                            mem_dat <= mem[cmd.addr[AW-1:0]];
                        end
                    end
                end
                M_READ: begin
                    if (cmd_vld) begin
                        state   <= M_IDLE;
                        mem_vld <= 1'b0;
                    end else if (mem_vld && chip_rdy) begin
                        // Word taken, next address
                        ptr     <= ptr + 1'b1;
                        mem_dat <= mem[ptr + 1'b1];
                        mem_vld <= no_stall();
                    end else if (!mem_vld) begin
                        mem_vld <= no_stall();
                    end
                end
                M_WRITE: begin
                    if (cmd_vld) begin
                        state   <= M_IDLE;
                        mem_rdy <= 1'b0;
                    end else begin
                        if (chip_vld && mem_rdy) begin
                            mem[ptr] <= chip_dat;
                            ptr      <= ptr + 1'b1;
                        end
                        mem_rdy <= no_stall();
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

endmodule

// ==== verif/accel_asserts.sv ====
`timescale 1ns/1ps

module accel_asserts #(
    parameter int PORT_WIDTH = 128
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cmd_vld,
    input  logic                             dat_oe,
    input  logic                             chip_vld,
    input  logic [PORT_WIDTH-1:0]            chip_dat,
    input  logic                             mem_rdy,
    input  logic [accel_pkg::MEM_ADDR_W-1:0] src_addr,
    input  logic [accel_pkg::MEM_ADDR_W-1:0] dst_addr
);
    import accel_pkg::*;

    localparam int PAD_W = PORT_WIDTH - MEM_ADDR_W - 1;

    // Pulse count in a run: load open, load close, store open, store close
    logic [1:0] pulses;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pulses <= '0;
        end else if (cmd_vld) begin
            pulses <= pulses + 1'b1;
        end
    end

    // ==============================
    // Port protocol
    // ==============================
    a_cmd_single: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_vld |=> !cmd_vld)
        else $error("cmd_vld stayed high for two cycles");

    // Load command, direction 0 in bit 0
    a_load_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_vld && pulses == 2'd0) |=>
            (chip_vld && chip_dat == {{PAD_W{1'b0}}, src_addr, 1'b0}))
        else $error("load command word does not carry src_addr and the load direction");

    // Store command, direction 1 in bit 0
    a_store_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_vld && pulses == 2'd2) |=>
            (chip_vld && chip_dat == {{PAD_W{1'b0}}, dst_addr, 1'b1}))
        else $error("store command word does not carry dst_addr and the store direction");

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (chip_vld && !mem_rdy) |=> (chip_vld && $stable(chip_dat)))
        else $error("chip word or valid changed while mem_rdy was low");

    a_vld_oe: assert property (@(posedge clk) disable iff (!rst_n)
        chip_vld |-> dat_oe)
        else $error("chip_vld high while the chip does not own the data path");

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import accel_pkg::*;

    localparam int PORT_WIDTH = 128;
    localparam int BUF_DEPTH  = 16;
    localparam int MEM_DEPTH  = 4096;
    localparam int CNT_W      = $clog2(BUF_DEPTH + 1);
    localparam int LANES      = PORT_WIDTH / LANE_W;
    localparam int RUNS       = 8;
    localparam int RUN_LIMIT  = 2000;

    // One run of the chip
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] src;
        logic [MEM_ADDR_W-1:0] dst;
        logic [CNT_W-1:0]      cnt;
    } run_cfg_t;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    logic [MEM_ADDR_W-1:0] src_addr;
    logic [MEM_ADDR_W-1:0] dst_addr;
    logic [CNT_W-1:0]      word_cnt;
    logic [PORT_WIDTH-1:0] mem_dat;
    logic                  mem_vld;
    logic                  mem_rdy;
    logic                  dat_oe;
    logic                  cmd_vld;
    logic [PORT_WIDTH-1:0] chip_dat;
    logic                  chip_vld;
    logic                  chip_rdy;
    logic                  net_fnh;
    logic                  busy;

    int                    errors      = 0;
    int                    checks      = 0;
    int                    pulse_total = 0;
    bit                    stalled     = 1'b0;
    bit                    closed      = 1'b0;
    logic [PORT_WIDTH-1:0] src_copy [BUF_DEPTH];

    accel_top #(
        .PORT_WIDTH (PORT_WIDTH),
        .BUF_DEPTH  (BUF_DEPTH)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .src_addr (src_addr),
        .dst_addr (dst_addr),
        .word_cnt (word_cnt),
        .mem_dat  (mem_dat),
        .mem_vld  (mem_vld),
        .mem_rdy  (mem_rdy),
        .dat_oe   (dat_oe),
        .cmd_vld  (cmd_vld),
        .chip_dat (chip_dat),
        .chip_vld (chip_vld),
        .chip_rdy (chip_rdy),
        .net_fnh  (net_fnh),
        .busy     (busy)
    );

    offchip_mem #(
        .PORT_WIDTH (PORT_WIDTH),
        .DEPTH      (MEM_DEPTH)
    ) u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .dat_oe   (dat_oe),
        .cmd_vld  (cmd_vld),
        .chip_dat (chip_dat),
        .chip_vld (chip_vld),
        .chip_rdy (chip_rdy),
        .mem_dat  (mem_dat),
        .mem_vld  (mem_vld),
        .mem_rdy  (mem_rdy)
    );

    bind accel_top accel_asserts #(
        .PORT_WIDTH (PORT_WIDTH)
    ) u_asserts (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_vld  (cmd_vld),
        .dat_oe   (dat_oe),
        .chip_vld (chip_vld),
        .chip_dat (chip_dat),
        .mem_rdy  (mem_rdy),
        .src_addr (src_addr),
        .dst_addr (dst_addr)
    );

    always #2 clk = ~clk;

    // Port pulses, sampled away from the active edge
    always @(negedge clk) begin
        if (cmd_vld) begin
            pulse_total <= pulse_total + 1;
        end
    end

    // ==============================
    // Reference and check helpers
    // ==============================

    // Negative signed lanes become zero
    function automatic logic [PORT_WIDTH-1:0] clip_negative_lanes(
        input logic [PORT_WIDTH-1:0] w
    );
        logic [PORT_WIDTH-1:0] r;
        r = w;
        for (int i = 0; i < LANES; i++) begin
            if ($signed(w[i*LANE_W +: LANE_W]) < 0) begin
                r[i*LANE_W +: LANE_W] = '0;
            end
        end
        return r;
    endfunction

    task automatic expect_equal(input string name, input logic [PORT_WIDTH-1:0] got,
                                input logic [PORT_WIDTH-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // First run one word, second a full buffer, the rest in between
    function automatic run_cfg_t pick_run(input int r);
        run_cfg_t cfg;
        cfg.src = MEM_ADDR_W'($urandom % (MEM_DEPTH / 2 - BUF_DEPTH));
        cfg.dst = MEM_ADDR_W'(MEM_DEPTH / 2 + $urandom % (MEM_DEPTH / 2 - BUF_DEPTH));
        if (r == 0) begin
            cfg.cnt = CNT_W'(1);
        end else if (r == 1) begin
            cfg.cnt = CNT_W'(BUF_DEPTH);
        end else begin
            cfg.cnt = CNT_W'(2 + $urandom % (BUF_DEPTH - 2));
        end
        return cfg;
    endfunction

    // Block results, then the finish flag held while idle
    task automatic check_results(input run_cfg_t cfg, input int pulses_before);
        int idle_n;
        for (int i = 0; i < int'(cfg.cnt); i++) begin
            expect_equal($sformatf("mem[%0d]", cfg.dst + i), u_mem.mem[cfg.dst + i],
                         clip_negative_lanes(src_copy[i]));
            expect_equal($sformatf("mem[%0d]", cfg.src + i), u_mem.mem[cfg.src + i],
                         src_copy[i]);
        end
        // Exactly two transactions, the extra start did nothing
        expect_equal("cmd_vld pulses", pulse_total - pulses_before, 4);
        idle_n = 4 + $urandom % 12;
        for (int c = 0; c < idle_n; c++) begin
            @(negedge clk);
            expect_equal("net_fnh", net_fnh, 1'b1);
            expect_equal("busy", busy, 1'b0);
            expect_equal("cmd_vld", cmd_vld, 1'b0);
        end
    endtask

    task automatic run_block(input run_cfg_t cfg);
        int pulses_before;
        int wait_n;
        for (int i = 0; i < BUF_DEPTH; i++) begin
            src_copy[i] = u_mem.mem[cfg.src + i];
        end
        pulses_before = pulse_total;
        @(posedge clk);
        start    <= 1'b1;
        src_addr <= cfg.src;
        dst_addr <= cfg.dst;
        word_cnt <= cfg.cnt;
        @(posedge clk);
        start <= 1'b0;
        wait_n = 0;
        do begin
            @(negedge clk);
            wait_n++;
        end while (!busy && wait_n < 10);
        if (!busy) begin
            errors++;
            stalled = 1'b1;
            $display("busy did not rise within 10 cycles of start at %0t", $time);
        end else begin
            expect_equal("net_fnh", net_fnh, 1'b0);
            // Start during the load, must be ignored
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            wait_n = 0;
            do begin
                @(negedge clk);
                wait_n++;
            end while (!net_fnh && wait_n < RUN_LIMIT);
            if (!net_fnh) begin
                errors++;
                stalled = 1'b1;
                $display("net_fnh did not rise within %0d cycles, run hung", RUN_LIMIT);
            end else begin
                check_results(cfg, pulses_before);
            end
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        run_cfg_t cfg;
        void'($urandom(32'h9e8a4ba3));
        clk      = 1'b0;
        rst_n    = 1'b0;
        start    = 1'b0;
        src_addr = '0;
        dst_addr = '0;
        word_cnt = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        // Quiet port after reset
        expect_equal("cmd_vld", cmd_vld, 1'b0);
        expect_equal("dat_oe", dat_oe, 1'b0);
        expect_equal("chip_vld", chip_vld, 1'b0);
        expect_equal("chip_rdy", chip_rdy, 1'b0);
        expect_equal("busy", busy, 1'b0);
        expect_equal("net_fnh", net_fnh, 1'b0);
        for (int r = 0; r < RUNS && !stalled; r++) begin
            cfg = pick_run(r);
            run_block(cfg);
        end
        closed = 1'b1;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Run stopped early, e.g. by a protocol assertion
    final begin
        if (!closed) begin
            $display("Simulation stopped before the closing checks");
            $display("Something failed");
        end
    end

endmodule

// ==== sim.f ====
src/accel_pkg.sv
src/word_buf.sv
src/relu_unit.sv
src/port_ctrl.sv
src/net_seq.sv
src/accel_top.sv
verif/offchip_mem.sv
verif/accel_asserts.sv
verif/tb_top.sv

// ==== Makefile ====
TOP = tb_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wno-fatal -f sim.f --top-module $(TOP)

obj_dir/V$(TOP): sim.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -q "Everything OK" sim.log || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir sim.log
